/* verilog/motion_config.svh */
/*
  motion channel configuration macros
  host port widths, position and pwm value widths
  register map and pwm period reset value
  encoder input synchronizer depth
*/
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// host register port
`define MOTION_DATA_WIDTH 16
`define MOTION_ADDR_WIDTH 3

// encoder count and pwm value widths
`define QE_COUNT_WIDTH 16
`define PWM_WIDTH 16

// flops between the encoder pins and the decoder
`define QE_SYNC_STAGES 2

// register map, sized to the address width
`define REG_CONTROL   3'd0
`define REG_DUTY      3'd1
`define REG_PERIOD    3'd2
`define REG_POSITION  3'd3
`define REG_INDEX_POS 3'd4
`define REG_STATUS    3'd5

// period after reset, 256 clock window
`define PWM_PERIOD_RESET 16'd255

`endif

/* verilog/motion_pkg.sv */
/*
  shared types of the motion channel
  host address and data vectors
  signed encoder count and pwm value vectors
  encoder phase state enum
*/
`default_nettype none

`include "motion_config.svh"

package motion_pkg;

   // host register port
   typedef logic [`MOTION_ADDR_WIDTH-1:0] bus_addr_t;
   typedef logic [`MOTION_DATA_WIDTH-1:0] bus_data_t;

   // position wraps as a 16 bit two's complement count
   typedef logic signed [`QE_COUNT_WIDTH-1:0] qe_count_t;

   // duty and period, both in clock cycles
   typedef logic [`PWM_WIDTH-1:0] pwm_value_t;

   // last seen encoder phase, encoded as {a, b}
   // forward order is 00 -> 01 -> 11 -> 10 -> 00
   typedef enum logic [1:0] {
      phase_00 = 2'b00,
      phase_01 = 2'b01,
      phase_11 = 2'b11,
      phase_10 = 2'b10
   } qe_phase_t;

endpackage

`default_nettype wire

/* verilog/qe_decoder.sv */
/*
  quadrature encoder decoder
  input synchronizers on a, b and index
  phase tracking with up, down and error detection
  position counter with preset, index position latch
*/
`timescale 1ns/10ps
`default_nettype none

`include "motion_config.svh"

module qe_decoder (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  quad_a,
   input  logic                  quad_b,
   input  logic                  quad_i,
   input  logic                  pos_load,
   input  logic                  err_clear,
   input  motion_pkg::qe_count_t pos_load_value,
   output motion_pkg::qe_count_t position,
   output motion_pkg::qe_count_t index_pos,
   output logic                  phase_err
);

   localparam int SYNC_MSB = `QE_SYNC_STAGES - 1;

   // synchronizer chains, new sample enters at bit 0
   logic [SYNC_MSB:0] sync_a;
   logic [SYNC_MSB:0] sync_b;
   logic [SYNC_MSB:0] sync_i;
   logic              index_prev;

   motion_pkg::qe_phase_t last_phase;
   motion_pkg::qe_phase_t cur_phase;
   logic                  step_up;
   logic                  step_down;
   logic                  step_bad;

   // phase as seen after the last sync stage
   assign cur_phase = motion_pkg::qe_phase_t'({sync_a[SYNC_MSB], sync_b[SYNC_MSB]});

   // classify the move from last_phase to cur_phase
   // no change leaves all three low
   always_comb begin
      step_up   = 1'b0;
      step_down = 1'b0;
      step_bad  = 1'b0;
      case (last_phase)
         motion_pkg::phase_00: begin
            step_up   = (cur_phase == motion_pkg::phase_01);
            step_down = (cur_phase == motion_pkg::phase_10);
            step_bad  = (cur_phase == motion_pkg::phase_11);
         end
         motion_pkg::phase_01: begin
            step_up   = (cur_phase == motion_pkg::phase_11);
            step_down = (cur_phase == motion_pkg::phase_00);
            step_bad  = (cur_phase == motion_pkg::phase_10);
         end
         motion_pkg::phase_11: begin
            step_up   = (cur_phase == motion_pkg::phase_10);
            step_down = (cur_phase == motion_pkg::phase_01);
            step_bad  = (cur_phase == motion_pkg::phase_00);
         end
         motion_pkg::phase_10: begin
            step_up   = (cur_phase == motion_pkg::phase_00);
            step_down = (cur_phase == motion_pkg::phase_11);
            step_bad  = (cur_phase == motion_pkg::phase_01);
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sync_a     <= '0;
         sync_b     <= '0;
         sync_i     <= '0;
         index_prev <= 1'b0;
         last_phase <= motion_pkg::phase_00;
         position   <= '0;
         index_pos  <= '0;
         phase_err  <= 1'b0;
      end else begin
         sync_a     <= {sync_a[SYNC_MSB-1:0], quad_a};
         sync_b     <= {sync_b[SYNC_MSB-1:0], quad_b};
         sync_i     <= {sync_i[SYNC_MSB-1:0], quad_i};
         index_prev <= sync_i[SYNC_MSB];
         // follow the pins even after a bad jump
         last_phase <= cur_phase;

         // host preset beats a step in the same cycle
         if (pos_load)
            position <= pos_load_value;
         else if (step_up)
            position <= position + 1'b1;
         else if (step_down)
            position <= position - 1'b1;

         // count before this cycle's step
         if (sync_i[SYNC_MSB] && !index_prev)
            index_pos <= position;

         // sticky, a fresh error wins over a clear
         if (step_bad)
            phase_err <= 1'b1;
         else if (err_clear)
            phase_err <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* verilog/pwm_generator.sv */
/*
  pwm generator
  period counter held at zero while disabled
  duty compare with registered pwm output
  h-bridge direction steering
*/
`timescale 1ns/10ps
`default_nettype none

module pwm_generator (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable,
   input  logic                   direction,
   input  motion_pkg::pwm_value_t duty,
   input  motion_pkg::pwm_value_t period,
   output logic                   pwm_out,
   output logic                   h_bridge_1,
   output logic                   h_bridge_2
);

   // position inside the current window, 0 .. period
   motion_pkg::pwm_value_t count;

   // high part of the window
   logic pwm_active;

   // last count of the window
   logic window_end;

   assign window_end = (count >= period);

   // enable gates the compare so a disabled channel never drives
   assign pwm_active = enable && (count < duty);

   // window counter
   // held at zero while disabled, so enabling starts a fresh window
   // >= also recovers when period is lowered below the count
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (!enable) begin
         count <= '0;
      end else if (window_end) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // registered outputs
   // all three lines come from the same compare in the same cycle
   // so the selected bridge line mirrors pwm_out exactly
   // duty above period gives a line held high for the whole window
   always_ff @(posedge clk) begin
      if (rst) begin
         pwm_out    <= 1'b0;
         h_bridge_1 <= 1'b0;
         h_bridge_2 <= 1'b0;
      end else begin
         pwm_out    <= pwm_active;
         // direction 0 drives side 1
         h_bridge_1 <= pwm_active && !direction;
         // direction 1 drives side 2
         h_bridge_2 <= pwm_active && direction;
      end
   end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
/*
  host register bank
  control, duty and period registers
  position preset and error clear pulses to the decoder
  registered read multiplexer with one cycle valid strobe
*/
`timescale 1ns/10ps
`default_nettype none

`include "motion_config.svh"

module register_bank (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   wr_strobe,
   input  logic                   rd_strobe,
   input  motion_pkg::bus_addr_t  wr_addr,
   input  motion_pkg::bus_addr_t  rd_addr,
   input  motion_pkg::bus_data_t  wr_data,
   input  motion_pkg::qe_count_t  position,
   input  motion_pkg::qe_count_t  index_pos,
   input  logic                   phase_err,
   output logic                   rd_valid,
   output motion_pkg::bus_data_t  rd_data,
   output logic                   enable,
   output logic                   direction,
   output motion_pkg::pwm_value_t duty,
   output motion_pkg::pwm_value_t period,
   output logic                   pos_load,
   output logic                   err_clear,
   output motion_pkg::qe_count_t  pos_load_value
);

   // next read answer
   motion_pkg::bus_data_t rd_mux;

   // decoder side pulses, one cycle wide with the write strobe
   // the decoder registers them, so a preset shows in the next cycle
   assign pos_load       = wr_strobe && (wr_addr == `REG_POSITION);
   assign err_clear      = wr_strobe && (wr_addr == `REG_STATUS);
   assign pos_load_value = motion_pkg::qe_count_t'(wr_data);

   // pwm settings
   always_ff @(posedge clk) begin
      if (rst) begin
         enable    <= 1'b0;
         direction <= 1'b0;
         duty      <= '0;
         period    <= `PWM_PERIOD_RESET;
      end else if (wr_strobe) begin
         case (wr_addr)
            `REG_CONTROL: begin
               enable    <= wr_data[0];
               direction <= wr_data[1];
            end
            `REG_DUTY:
               duty <= motion_pkg::pwm_value_t'(wr_data);
            `REG_PERIOD:
               period <= motion_pkg::pwm_value_t'(wr_data);
            // position and status are handled by the pulses above
            default: ;
         endcase
      end
   end

   // read select over both parts and the local settings
   always_comb begin
      rd_mux = '0;
      case (rd_addr)
         `REG_CONTROL: begin
            rd_mux[0] = enable;
            rd_mux[1] = direction;
         end
         `REG_DUTY:
            rd_mux = motion_pkg::bus_data_t'(duty);
         `REG_PERIOD:
            rd_mux = motion_pkg::bus_data_t'(period);
         `REG_POSITION:
            rd_mux = motion_pkg::bus_data_t'(position);
         `REG_INDEX_POS:
            rd_mux = motion_pkg::bus_data_t'(index_pos);
         `REG_STATUS:
            rd_mux[0] = phase_err;
         // unused addresses read as zero
         default: rd_mux = '0;
      endcase
   end

   // answer one cycle after the request
   // back to back strobes give back to back answers
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid <= 1'b0;
         rd_data  <= '0;
      end else begin
         rd_valid <= rd_strobe;
         // data holds between reads
         if (rd_strobe)
            rd_data <= rd_mux;
      end
   end

endmodule

`default_nettype wire

/* verilog/motion_channel.sv */
/*
  motion channel top level
  encoder decoder, pwm generator and host register bank
*/
`timescale 1ns/10ps
`default_nettype none

module motion_channel (
   input  logic                  clk,
   input  logic                  rst,
   // host port
   input  logic                  wr_strobe,
   input  motion_pkg::bus_addr_t wr_addr,
   input  motion_pkg::bus_data_t wr_data,
   input  logic                  rd_strobe,
   input  motion_pkg::bus_addr_t rd_addr,
   output logic                  rd_valid,
   output motion_pkg::bus_data_t rd_data,
   // encoder pins, asynchronous
   input  logic                  quad_a,
   input  logic                  quad_b,
   input  logic                  quad_i,
   // motor drive
   output logic                  pwm_out,
   output logic                  h_bridge_1,
   output logic                  h_bridge_2
);

   // decoder results
   motion_pkg::qe_count_t  position;
   motion_pkg::qe_count_t  index_pos;
   logic                   phase_err;

   // decoder controls
   logic                   pos_load;
   logic                   err_clear;
   motion_pkg::qe_count_t  pos_load_value;

   // pwm settings
   logic                   enable;
   logic                   direction;
   motion_pkg::pwm_value_t duty;
   motion_pkg::pwm_value_t period;

   qe_decoder qe_ch (
      .clk            (clk),
      .rst            (rst),
      .quad_a         (quad_a),
      .quad_b         (quad_b),
      .quad_i         (quad_i),
      .pos_load       (pos_load),
      .err_clear      (err_clear),
      .pos_load_value (pos_load_value),
      .position       (position),
      .index_pos      (index_pos),
      .phase_err      (phase_err)
   );

   pwm_generator pwm_ch (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .direction  (direction),
      .duty       (duty),
      .period     (period),
      .pwm_out    (pwm_out),
      .h_bridge_1 (h_bridge_1),
      .h_bridge_2 (h_bridge_2)
   );

   register_bank reg_bank (
      .clk            (clk),
      .rst            (rst),
      .wr_strobe      (wr_strobe),
      .rd_strobe      (rd_strobe),
      .wr_addr        (wr_addr),
      .rd_addr        (rd_addr),
      .wr_data        (wr_data),
      .position       (position),
      .index_pos      (index_pos),
      .phase_err      (phase_err),
      .rd_valid       (rd_valid),
      .rd_data        (rd_data),
      .enable         (enable),
      .direction      (direction),
      .duty           (duty),
      .period         (period),
      .pos_load       (pos_load),
      .err_clear      (err_clear),
      .pos_load_value (pos_load_value)
   );

endmodule

`default_nettype wire

/* tests/motion_channel_properties.sv */
/*
  concurrent assertions for the motion channel top level
  read answer timing, h-bridge exclusion, pwm gating by enable
  output state after reset, bound into every motion_channel
*/
`timescale 1ns/10ps
`default_nettype none

module motion_channel_properties (
   input wire logic                  clk,
   input wire logic                  rst,
   input wire logic                  rd_strobe,
   input wire logic                  rd_valid,
   input wire motion_pkg::bus_data_t rd_data,
   input wire logic                  enable,
   input wire logic                  pwm_out,
   input wire logic                  h_bridge_1,
   input wire logic                  h_bridge_2
);

   // answer comes exactly one cycle after each request
   rd_valid_timing: assert property (
      @(posedge clk) !rst |=> (rd_valid == $past(rd_strobe))
   ) else $error("rd_valid does not follow rd_strobe by one cycle");

   // shoot-through guard
   bridge_exclusive: assert property (
      @(posedge clk) !(h_bridge_1 && h_bridge_2)
   ) else $error("h_bridge_1 and h_bridge_2 high together");

   // pwm_out is registered, so it lags enable by one cycle
   pwm_gated: assert property (
      @(posedge clk) !enable |=> !pwm_out
   ) else $error("pwm_out high while enable is low");

   // everything quiet right after a reset cycle
   reset_outputs: assert property (
      @(posedge clk) rst |=> (!rd_valid && rd_data == '0 && !pwm_out
                              && !h_bridge_1 && !h_bridge_2)
   ) else $error("outputs not low after reset");

endmodule

bind motion_channel motion_channel_properties props (
   .clk        (clk),
   .rst        (rst),
   .rd_strobe  (rd_strobe),
   .rd_valid   (rd_valid),
   .rd_data    (rd_data),
   .enable     (enable),
   .pwm_out    (pwm_out),
   .h_bridge_1 (h_bridge_1),
   .h_bridge_2 (h_bridge_2)
);

`default_nettype wire

/* tests/motion_channel_tb.sv */
/*
  motion channel testbench
  clock, reset and a stimulus table applied in a loop
  host reads and writes, encoder stepping, pwm window measurement
  compare tasks and the closing report
*/
`timescale 1ns/10ps
`default_nettype none

`include "motion_config.svh"

module motion_channel_tb;

   localparam int RD_TIMEOUT  = 20;
   localparam int PWM_TIMEOUT = 1000;
   localparam int NUM_ROWS    = 39;

   // table operations
   localparam logic [2:0] OP_WRITE = 3'd0;
   localparam logic [2:0] OP_READ  = 3'd1;
   localparam logic [2:0] OP_FWD   = 3'd2;
   localparam logic [2:0] OP_REV   = 3'd3;
   localparam logic [2:0] OP_JUMP  = 3'd4;
   localparam logic [2:0] OP_INDEX = 3'd5;
   localparam logic [2:0] OP_PWM   = 3'd6;

   // encoder phases {a, b} in forward order
   localparam logic [1:0] FWD_ORDER [4] = '{2'b00, 2'b01, 2'b11, 2'b10};

   // row: {op, addr, data or step count, expected, random step count}
   localparam logic [38:0] STIM [NUM_ROWS] = '{
      {OP_READ,  `REG_CONTROL,   16'h0000, 16'h0000, 1'b0},
      {OP_READ,  `REG_PERIOD,    16'h0000, 16'h00ff, 1'b0},
      {OP_READ,  `REG_POSITION,  16'h0000, 16'h0000, 1'b0},
      {OP_READ,  `REG_STATUS,    16'h0000, 16'h0000, 1'b0},
      {OP_WRITE, `REG_DUTY,      16'h1234, 16'h0000, 1'b0},
      {OP_WRITE, `REG_CONTROL,   16'h0002, 16'h0000, 1'b0},
      {OP_READ,  `REG_DUTY,      16'h0000, 16'h1234, 1'b0},
      // unused address right after a nonzero answer
      {OP_READ,  3'd7,           16'h0000, 16'h0000, 1'b0},
      {OP_READ,  `REG_CONTROL,   16'h0000, 16'h0002, 1'b0},
      // preset near the top so the count wraps
      {OP_WRITE, `REG_POSITION,  16'h7ffe, 16'h0000, 1'b0},
      {OP_FWD,   3'd0,           16'd5,    16'h0000, 1'b0},
      {OP_READ,  `REG_POSITION,  16'h0000, 16'h8003, 1'b0},
      {OP_REV,   3'd0,           16'd7,    16'h0000, 1'b0},
      {OP_READ,  `REG_POSITION,  16'h0000, 16'h7ffc, 1'b0},
      {OP_INDEX, 3'd0,           16'h0000, 16'h0000, 1'b0},
      {OP_READ,  `REG_INDEX_POS, 16'h0000, 16'h7ffc, 1'b0},
      {OP_JUMP,  3'd0,           16'd1,    16'h0000, 1'b0},
      {OP_READ,  `REG_STATUS,    16'h0000, 16'h0001, 1'b0},
      {OP_READ,  `REG_POSITION,  16'h0000, 16'h7ffc, 1'b0},
      {OP_WRITE, `REG_STATUS,    16'h0000, 16'h0000, 1'b0},
      {OP_READ,  `REG_STATUS,    16'h0000, 16'h0000, 1'b0},
      // 10 cycle pwm window
      {OP_WRITE, `REG_PERIOD,    16'h0009, 16'h0000, 1'b0},
      {OP_READ,  `REG_PERIOD,    16'h0000, 16'h0009, 1'b0},
      {OP_WRITE, `REG_DUTY,      16'h0004, 16'h0000, 1'b0},
      {OP_WRITE, `REG_CONTROL,   16'h0001, 16'h0000, 1'b0},
      {OP_PWM,   3'd0,           16'h0000, 16'h0004, 1'b0},
      {OP_WRITE, `REG_DUTY,      16'h0019, 16'h0000, 1'b0},
      {OP_PWM,   3'd0,           16'h0000, 16'h000a, 1'b0},
      {OP_WRITE, `REG_DUTY,      16'h0000, 16'h0000, 1'b0},
      {OP_PWM,   3'd0,           16'h0000, 16'h0000, 1'b0},
      {OP_WRITE, `REG_DUTY,      16'h0006, 16'h0000, 1'b0},
      {OP_WRITE, `REG_CONTROL,   16'h0003, 16'h0000, 1'b0},
      {OP_PWM,   3'd0,           16'h0000, 16'h0006, 1'b0},
      {OP_WRITE, `REG_CONTROL,   16'h0002, 16'h0000, 1'b0},
      {OP_PWM,   3'd0,           16'h0000, 16'h0000, 1'b0},
      // random step counts, expected position from the model
      {OP_FWD,   3'd0,           16'h0000, 16'h0000, 1'b1},
      {OP_REV,   3'd0,           16'h0000, 16'h0000, 1'b1},
      {OP_FWD,   3'd0,           16'h0000, 16'h0000, 1'b1},
      {OP_READ,  `REG_POSITION,  16'h0000, 16'h0000, 1'b1}
   };

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  wr_strobe;
   motion_pkg::bus_addr_t wr_addr;
   motion_pkg::bus_data_t wr_data;
   logic                  rd_strobe;
   motion_pkg::bus_addr_t rd_addr;
   logic                  rd_valid;
   motion_pkg::bus_data_t rd_data;
   logic                  quad_a;
   logic                  quad_b;
   logic                  quad_i;
   logic                  pwm_out;
   logic                  h_bridge_1;
   logic                  h_bridge_2;

   int                    errors = 0;
   int                    timeouts = 0;
   integer                seed;
   // reference state kept from the stimulus
   motion_pkg::qe_count_t model_pos = '0;
   int                    enc_idx = 0;
   int                    cur_period = 255;
   logic                  cur_dir = 1'b0;

   motion_channel UUT (.*);

   always #50 clk = ~clk;

   task automatic check_data(input string name, input motion_pkg::bus_data_t expected,
                             input motion_pkg::bus_data_t actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input motion_pkg::qe_count_t expected,
                              input motion_pkg::qe_count_t actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected,
                  actual);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic write_reg(input motion_pkg::bus_addr_t addr, input motion_pkg::bus_data_t data);
      @(negedge clk);
      wr_strobe = 1'b1;
      wr_addr   = addr;
      wr_data   = data;
      @(negedge clk);
      wr_strobe = 1'b0;
   endtask

   task automatic read_reg(input motion_pkg::bus_addr_t addr, output motion_pkg::bus_data_t data);
      int waited;
      waited = 0;
      @(negedge clk);
      rd_strobe = 1'b1;
      rd_addr   = addr;
      @(negedge clk);
      rd_strobe = 1'b0;
      while (!rd_valid && waited < RD_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!rd_valid) begin
         $display("timeout: no read answer from address %0d", addr);
         timeouts++;
      end else if (waited != 0) begin
         $display("read answer from address %0d came %0d cycles late", addr, waited);
         errors++;
      end
      data = rd_data;
      // answer strobe lasts a single cycle
      @(negedge clk);
      check_bit("rd_valid", 1'b0, rd_valid);
   endtask

   // delta 1 is a forward step, 3 a reverse step, 2 an opposite-phase jump
   task automatic move_encoder(input int delta, input int count);
      for (int k = 0; k < count; k++) begin
         @(negedge clk);
         enc_idx = (enc_idx + delta) % 4;
         {quad_a, quad_b} = FWD_ORDER[enc_idx];
         if (delta == 1)
            model_pos = model_pos + 16'sd1;
         else if (delta == 3)
            model_pos = model_pos - 16'sd1;
         // 2 sync stages plus the count update
         repeat (4) @(negedge clk);
      end
   endtask

   task automatic measure_pwm(input motion_pkg::bus_data_t expected);
      int highs;
      int waited;
      highs  = 0;
      waited = 0;
      // new settings get a full window first
      repeat (cur_period + 2) @(negedge clk);
      while (expected != '0 && !pwm_out && waited < PWM_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (expected != '0 && !pwm_out) begin
         $display("timeout: pwm_out never went high");
         timeouts++;
      end
      // any period+1 consecutive cycles hold one full window
      for (int k = 0; k <= cur_period; k++) begin
         if (pwm_out)
            highs++;
         check_bit("h_bridge_1", pwm_out && !cur_dir, h_bridge_1);
         check_bit("h_bridge_2", pwm_out && cur_dir, h_bridge_2);
         @(negedge clk);
      end
      check_data("pwm_out high cycles", expected, motion_pkg::bus_data_t'(highs));
   endtask

   initial begin
      logic [2:0]            op;
      motion_pkg::bus_addr_t addr;
      motion_pkg::bus_data_t data;
      motion_pkg::bus_data_t expv;
      logic                  rnd;
      motion_pkg::bus_data_t rdata;
      motion_pkg::qe_count_t exp_count;
      int                    steps;

      seed      = 32'h37e3_cb26;
      rst       = 1'b1;
      wr_strobe = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      rd_strobe = 1'b0;
      rd_addr   = '0;
      quad_a    = 1'b0;
      quad_b    = 1'b0;
      quad_i    = 1'b0;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < NUM_ROWS; i++) begin
         op    = STIM[i][38:36];
         addr  = STIM[i][35:33];
         data  = STIM[i][32:17];
         expv  = STIM[i][16:1];
         rnd   = STIM[i][0];
         steps = int'(data);
         if (rnd)
            steps = ($random(seed) & 15) + 1;
         case (op)
            OP_WRITE: begin
               write_reg(addr, data);
               if (addr == `REG_POSITION)
                  model_pos = motion_pkg::qe_count_t'(data);
               if (addr == `REG_PERIOD)
                  cur_period = int'(data);
               if (addr == `REG_CONTROL)
                  cur_dir = data[1];
            end
            OP_READ: begin
               read_reg(addr, rdata);
               // position registers compare as signed counts
               if (addr == `REG_POSITION || addr == `REG_INDEX_POS) begin
                  exp_count = rnd ? model_pos : motion_pkg::qe_count_t'(expv);
                  check_count($sformatf("rd_data @%0d", addr), exp_count,
                              motion_pkg::qe_count_t'(rdata));
               end else begin
                  check_data($sformatf("rd_data @%0d", addr), expv, rdata);
               end
            end
            OP_FWD:  move_encoder(1, steps);
            OP_REV:  move_encoder(3, steps);
            OP_JUMP: move_encoder(2, 1);
            OP_INDEX: begin
               @(negedge clk);
               quad_i = 1'b1;
               repeat (4) @(negedge clk);
               quad_i = 1'b0;
               repeat (4) @(negedge clk);
            end
            OP_PWM:  measure_pwm(expv);
            default: ;
         endcase
      end

      $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/motion_pkg.sv
verilog/qe_decoder.sv
verilog/pwm_generator.sv
verilog/register_bank.sv
verilog/motion_channel.sv
tests/motion_channel_properties.sv
tests/motion_channel_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the motion channel testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module motion_channel_tb -o motion_channel_sim

output=$(./obj_dir/motion_channel_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1
